/* rtl/thumb_settings.svh */
// Widths, ARM encodings and Thumb format patterns for the decompressor
// Patterns are wildcards on the low 16 bits and some of them overlap
// The decode stage resolves overlaps by priority
`ifndef THUMB_SETTINGS_SVH
`define THUMB_SETTINGS_SVH

`define THUMB_W         16
`define ARM_W           32

`define COND_AL         4'd14           // Always execute
`define REG_SP          4'd13
`define REG_PC          4'd15

// ARM data processing opcodes, bits 24:21
`define OP_AND          4'd0
`define OP_EOR          4'd1
`define OP_SUB          4'd2
`define OP_RSB          4'd3
`define OP_ADD          4'd4
`define OP_ADC          4'd5
`define OP_SBC          4'd6
`define OP_RSC          4'd7
`define OP_TST          4'd8
`define OP_TEQ          4'd9
`define OP_CMP          4'd10
`define OP_CMN          4'd11
`define OP_ORR          4'd12
`define OP_MOV          4'd13
`define OP_BIC          4'd14
`define OP_MVN          4'd15

// Shift types, same code in Thumb and ARM
`define SH_LSL          2'b00
`define SH_LSR          2'b01
`define SH_ASR          2'b10
`define SH_ROR          2'b11

//////////////////////////////////////////////////
// Thumb formats
//////////////////////////////////////////////////
`define T_PAT_SWI       16'b1101_1111_????_????
`define T_PAT_BX        16'b0100_0111_0???_????
`define T_PAT_ADDSUB    16'b0001_1???_????_????
`define T_PAT_SHIFT     16'b000?_????_????_????
`define T_PAT_IMM8      16'b001?_????_????_????
`define T_PAT_ALU_LO    16'b0100_00??_????_????
`define T_PAT_ALU_HI    16'b0100_01??_????_????
`define T_PAT_BCOND     16'b1101_????_????_????
`define T_PAT_BUNCOND   16'b1110_0???_????_????

`endif

/* rtl/thumb_pkg.sv */
// Views of a Thumb halfword and of an ARM word
// Each union is only a set of field names over the same bits
package thumb_pkg;

//////////////////////////////////////////////////
// Thumb halfword
//////////////////////////////////////////////////

// Register formats (shift, add/sub, ALU)
typedef struct packed {
        logic [5:0]     top;            // Format bits, 15:10
        logic [3:0]     rn_op;          // Rn, op or shamt low bits
        logic [2:0]     rs;
        logic [2:0]     rd;
} thumb_reg_t;

// Immediate formats (imm8, branches, SWI)
typedef struct packed {
        logic [2:0]     top;            // 15:13
        logic [1:0]     op;             // 12:11
        logic [2:0]     rd;             // 10:8
        logic [7:0]     imm8;
} thumb_imm_t;

typedef union packed {
        thumb_reg_t     rg;
        thumb_imm_t     im;
} thumb_word_u;

//////////////////////////////////////////////////
// ARM word
//////////////////////////////////////////////////

// Data processing, also carries MUL and BX
typedef struct packed {
        logic [3:0]     cond;
        logic [1:0]     cls;            // 00 for data processing
        logic           imm;            // Operand2 is rotated imm8
        logic [3:0]     opcode;
        logic           s;              // Update flags
        logic [3:0]     rn;
        logic [3:0]     rd;
        logic [11:0]    operand2;
} arm_dp_t;

// B and BL
typedef struct packed {
        logic [3:0]     cond;
        logic [2:0]     tag;            // Always 101
        logic           link;
        logic [23:0]    offset24;       // Signed, in halfwords here
} arm_br_t;

typedef union packed {
        arm_dp_t        dp;
        arm_br_t        br;
} arm_word_u;

endpackage

/* rtl/thumb_dp_imm.sv */
// Shift by immediate, 3-bit add/sub and 8-bit immediate Thumb formats
// Purely combinational, translates every halfword whether it matches or not
// Only low registers are reachable so bit 3 of every register field is 0
`include "thumb_settings.svh"

module thumb_dp_imm
        import thumb_pkg::*;
(
        input  thumb_word_u     i_thumb,        // Low half of fetched word
        output arm_word_u       o_shift_arm,    // MOVS Rd, Rs, <sh> #n
        output arm_word_u       o_addsub_arm,   // ADDS/SUBS Rd, Rs, Rn/#n
        output arm_word_u       o_imm8_arm      // MOVS/CMP/ADDS/SUBS #imm8
);

//////////////////////////////////////////////////
// Shift by immediate
//////////////////////////////////////////////////

always_comb
begin
        o_shift_arm             = '0;
        o_shift_arm.dp.cond     = `COND_AL;
        o_shift_arm.dp.opcode   = `OP_MOV;
        o_shift_arm.dp.s        = 1'b1;
        o_shift_arm.dp.rd       = {1'b0, i_thumb.rg.rd};
        // Shamt from bits 10:6, type from 12:11, Rm is Rs
        o_shift_arm.dp.operand2 = {i_thumb.rg.top[0], i_thumb.rg.rn_op,
                                   i_thumb.rg.top[2:1], 1'b0,
                                   1'b0, i_thumb.rg.rs};
end

//////////////////////////////////////////////////
// Add/subtract low
//////////////////////////////////////////////////

always_comb
begin
        o_addsub_arm            = '0;
        o_addsub_arm.dp.cond    = `COND_AL;
        o_addsub_arm.dp.imm     = i_thumb.rg.top[0];    // Bit 10, #imm3 form
        o_addsub_arm.dp.opcode  = i_thumb.rg.rn_op[3] ? `OP_SUB : `OP_ADD; // Bit 9
        o_addsub_arm.dp.s       = 1'b1;
        o_addsub_arm.dp.rn      = {1'b0, i_thumb.rg.rs};
        o_addsub_arm.dp.rd      = {1'b0, i_thumb.rg.rd};
        // Rm with LSL #0 and imm3 with no rotate share one encoding
        o_addsub_arm.dp.operand2 = {9'd0, i_thumb.rg.rn_op[2:0]};
end

//////////////////////////////////////////////////
// MOV/CMP/ADD/SUB with 8-bit immediate
//////////////////////////////////////////////////

always_comb
begin
        o_imm8_arm              = '0;
        o_imm8_arm.dp.cond      = `COND_AL;
        o_imm8_arm.dp.imm       = 1'b1;
        o_imm8_arm.dp.s         = 1'b1;                 // All four set flags
        o_imm8_arm.dp.rn        = {1'b0, i_thumb.im.rd};
        o_imm8_arm.dp.rd        = {1'b0, i_thumb.im.rd};
        o_imm8_arm.dp.operand2  = {4'd0, i_thumb.im.imm8}; // Zero extended, no rotate
        case (i_thumb.im.op)
        2'd0:    o_imm8_arm.dp.opcode = `OP_MOV;
        2'd1:    o_imm8_arm.dp.opcode = `OP_CMP;
        2'd2:    o_imm8_arm.dp.opcode = `OP_ADD;
        default: o_imm8_arm.dp.opcode = `OP_SUB;
        endcase
end

endmodule

/* rtl/thumb_dp_alu.sv */
// Low register ALU format and high register ADD/CMP/MOV format
// Combinational, the decode stage decides whether either output is used
// High register op 3 has no translation and raises o_hi_und
`include "thumb_settings.svh"

module thumb_dp_alu
        import thumb_pkg::*;
(
        input  thumb_word_u     i_thumb,        // Low half of fetched word
        output arm_word_u       o_lo_arm,       // One of sixteen ALU forms
        output arm_word_u       o_hi_arm,       // ADD/CMP/MOV, zero for op 3
        output logic            o_hi_und        // High register op 3
);

logic [3:0] lo_rd;
logic [3:0] lo_rs;
logic [3:0] hi_rd;
logic [3:0] hi_rs;

assign lo_rd = {1'b0, i_thumb.rg.rd};
assign lo_rs = {1'b0, i_thumb.rg.rs};
assign hi_rd = {i_thumb.rg.rn_op[1], i_thumb.rg.rd};   // H1 is bit 7
assign hi_rs = {i_thumb.rg.rn_op[0], i_thumb.rg.rs};   // H2 is bit 6

//////////////////////////////////////////////////
// Low register ALU
//////////////////////////////////////////////////

always_comb
begin
        // Common form Rd = Rd op Rs, flags set
        o_lo_arm                = '0;
        o_lo_arm.dp.cond        = `COND_AL;
        o_lo_arm.dp.s           = 1'b1;
        o_lo_arm.dp.rn          = lo_rd;
        o_lo_arm.dp.rd          = lo_rd;
        o_lo_arm.dp.operand2    = {8'd0, lo_rs};

        case (i_thumb.rg.rn_op)
        4'd0:   o_lo_arm.dp.opcode = `OP_AND;
        4'd1:   o_lo_arm.dp.opcode = `OP_EOR;
        4'd2:                                   // LSL Rd, Rs
        begin
                o_lo_arm.dp.opcode   = `OP_MOV;
                o_lo_arm.dp.operand2 = {lo_rs, 1'b0, `SH_LSL, 1'b1, lo_rd};
        end
        4'd3:                                   // LSR Rd, Rs
        begin
                o_lo_arm.dp.opcode   = `OP_MOV;
                o_lo_arm.dp.operand2 = {lo_rs, 1'b0, `SH_LSR, 1'b1, lo_rd};
        end
        4'd4:                                   // ASR Rd, Rs
        begin
                o_lo_arm.dp.opcode   = `OP_MOV;
                o_lo_arm.dp.operand2 = {lo_rs, 1'b0, `SH_ASR, 1'b1, lo_rd};
        end
        4'd5:   o_lo_arm.dp.opcode = `OP_ADC;
        4'd6:   o_lo_arm.dp.opcode = `OP_SBC;
        4'd7:                                   // ROR Rd, Rs
        begin
                o_lo_arm.dp.opcode   = `OP_MOV;
                o_lo_arm.dp.operand2 = {lo_rs, 1'b0, `SH_ROR, 1'b1, lo_rd};
        end
        4'd8:   o_lo_arm.dp.opcode = `OP_TST;
        4'd9:                                   // NEG is RSBS Rd, Rs, #0
        begin
                o_lo_arm.dp.imm      = 1'b1;
                o_lo_arm.dp.opcode   = `OP_RSB;
                o_lo_arm.dp.rn       = lo_rs;
                o_lo_arm.dp.operand2 = 12'd0;
        end
        4'd10:  o_lo_arm.dp.opcode = `OP_CMP;
        4'd11:  o_lo_arm.dp.opcode = `OP_CMN;
        4'd12:  o_lo_arm.dp.opcode = `OP_ORR;
        4'd13:                                  // MULS Rd, Rs, Rd
        begin
                o_lo_arm.dp.opcode   = 4'd0;    // MUL lives in opcode 0 space
                o_lo_arm.dp.rn       = lo_rd;   // Destination sits at 19:16
                o_lo_arm.dp.rd       = 4'd0;    // Accumulator unused
                o_lo_arm.dp.operand2 = {lo_rd, 4'b1001, lo_rs};
        end
        4'd14:  o_lo_arm.dp.opcode = `OP_BIC;
        default: o_lo_arm.dp.opcode = `OP_MVN;
        endcase
end

//////////////////////////////////////////////////
// High register ADD/CMP/MOV
//////////////////////////////////////////////////

always_comb
begin
        o_hi_und                = 1'b0;
        o_hi_arm                = '0;
        o_hi_arm.dp.cond        = `COND_AL;
        o_hi_arm.dp.rn          = hi_rd;
        o_hi_arm.dp.rd          = hi_rd;
        o_hi_arm.dp.operand2    = {8'd0, hi_rs};

        case (i_thumb.rg.rn_op[3:2])            // Op in bits 9:8
        2'd0:   o_hi_arm.dp.opcode = `OP_ADD;   // Flags untouched
        2'd1:
        begin
                o_hi_arm.dp.opcode = `OP_CMP;
                o_hi_arm.dp.s      = 1'b1;
        end
        2'd2:   o_hi_arm.dp.opcode = `OP_MOV;   // Flags untouched
        default:
        begin
                o_hi_arm = '0;                  // BX slot, taken by decode stage
                o_hi_und = 1'b1;
        end
        endcase
end

endmodule

/* rtl/thumb_branch_dec.sv */
// Conditional and unconditional branch, BX and SWI
// Branch offsets stay in halfwords, the consumer doubles them
// Condition 1111 of the conditional branch is SWI and is sorted out downstream
`include "thumb_settings.svh"

module thumb_branch_dec
        import thumb_pkg::*;
(
        input  thumb_word_u     i_thumb,        // Low half of fetched word
        output arm_word_u       o_bcond_arm,    // B<cond> with 8-bit offset
        output arm_word_u       o_buncond_arm,  // B with 11-bit offset
        output arm_word_u       o_bx_arm,       // BX Rm
        output arm_word_u       o_swi_arm       // SWI #imm8
);

//////////////////////////////////////////////////
// Branches
//////////////////////////////////////////////////

always_comb
begin
        o_bcond_arm             = '0;
        o_bcond_arm.br.cond     = {i_thumb.im.op[0], i_thumb.im.rd};    // Bits 11:8
        o_bcond_arm.br.tag      = 3'b101;
        o_bcond_arm.br.link     = 1'b0;
        o_bcond_arm.br.offset24 = {{16{i_thumb.im.imm8[7]}}, i_thumb.im.imm8};
end

always_comb
begin
        o_buncond_arm           = '0;
        o_buncond_arm.br.cond   = `COND_AL;
        o_buncond_arm.br.tag    = 3'b101;
        o_buncond_arm.br.link   = 1'b0;
        // Sign extend bits 10:0
        o_buncond_arm.br.offset24 = {{13{i_thumb.rg.top[0]}}, i_thumb.rg.top[0],
                                     i_thumb.rg.rn_op, i_thumb.rg.rs, i_thumb.rg.rd};
end

//////////////////////////////////////////////////
// BX and SWI
//////////////////////////////////////////////////

// BX is 0x012FFF1m, the three SBO fields are all ones
assign o_bx_arm  = {`COND_AL, 8'h12, `REG_PC, `REG_PC, `REG_PC, 4'h1,
                    i_thumb.rg.rn_op[0], i_thumb.rg.rs};        // Rm from bits 6:3

assign o_swi_arm = {`COND_AL, 4'b1111, 16'd0, i_thumb.im.imm8}; // Comment field

endmodule

/* rtl/thumb_decode_stage.sv */
// Classifies the Thumb halfword, picks one candidate ARM word, registers result
// One cycle latency, a word may arrive every cycle, no back-pressure
// With valid low the outputs are still loaded and only o_instruction_valid counts
`include "thumb_settings.svh"

module thumb_decode_stage
        import thumb_pkg::*;
(
        input  logic                    i_clk,
        input  logic                    i_rst,

        // Fetch side
        input  logic [`ARM_W-1:0]       i_instruction,
        input  logic                    i_instruction_valid,
        input  logic                    i_cpsr_t,       // Thumb state

        // Candidates from the decoders
        input  arm_word_u               i_shift_arm,
        input  arm_word_u               i_addsub_arm,
        input  arm_word_u               i_imm8_arm,
        input  arm_word_u               i_lo_arm,
        input  arm_word_u               i_hi_arm,
        input  arm_word_u               i_bcond_arm,
        input  arm_word_u               i_buncond_arm,
        input  arm_word_u               i_bx_arm,
        input  arm_word_u               i_swi_arm,
        input  logic                    i_hi_und,       // High register op 3

        // To the ARM decoder
        output logic [`ARM_W-1:0]       o_instruction,
        output logic                    o_instruction_valid,
        output logic                    o_und,
        output logic                    o_half_offset   // Offset in halfwords
);

logic [`THUMB_W-1:0]    thumb;
logic [`ARM_W-1:0]      nxt_instruction;
logic                   nxt_und;
logic                   nxt_half;

assign thumb = i_instruction[`THUMB_W-1:0];

//////////////////////////////////////////////////
// Format select
//////////////////////////////////////////////////

always_comb
begin
        nxt_instruction = i_instruction;        // ARM state passes through
        nxt_und         = 1'b0;
        nxt_half        = 1'b0;

        if (i_instruction_valid && i_cpsr_t)
        begin
                // SWI before B<cond>, ADD/SUB before shift, BX before high ALU
                if (thumb ==? `T_PAT_SWI)
                        nxt_instruction = i_swi_arm;
                else if (thumb ==? `T_PAT_ADDSUB)
                        nxt_instruction = i_addsub_arm;
                else if (thumb ==? `T_PAT_BX)
                        nxt_instruction = i_bx_arm;
                else if (thumb ==? `T_PAT_SHIFT)
                        nxt_instruction = i_shift_arm;
                else if (thumb ==? `T_PAT_IMM8)
                        nxt_instruction = i_imm8_arm;
                else if (thumb ==? `T_PAT_ALU_LO)
                        nxt_instruction = i_lo_arm;
                else if (thumb ==? `T_PAT_ALU_HI)
                begin
                        nxt_instruction = i_hi_arm;
                        nxt_und         = i_hi_und;
                end
                else if (thumb ==? `T_PAT_BCOND)
                begin
                        nxt_instruction = i_bcond_arm;
                        nxt_half        = 1'b1;
                end
                else if (thumb ==? `T_PAT_BUNCOND)
                begin
                        nxt_instruction = i_buncond_arm;
                        nxt_half        = 1'b1;
                end
                else
                        nxt_und         = 1'b1; // Loads, stores, stack, BL
        end
end

//////////////////////////////////////////////////
// Output register
//////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_rst)
        begin
                o_instruction       <= '0;
                o_instruction_valid <= 1'b0;
                o_und               <= 1'b0;
                o_half_offset       <= 1'b0;
        end
        else
        begin
                o_instruction       <= nxt_instruction;
                o_instruction_valid <= i_instruction_valid;
                o_und               <= nxt_und;
                o_half_offset       <= nxt_half;
        end
end

// Branch words are never undefined
a_und_half: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_und && o_half_offset));

// ARM state word reaches the output untouched one cycle later
a_arm_pass: assert property (@(posedge i_clk) disable iff (i_rst)
        (!i_rst && !i_cpsr_t) |=> (o_instruction == $past(i_instruction)));

endmodule

/* rtl/thumb_decompress_top.sv */
// Thumb to ARM decompressor, result one clock after the fetched word
// i_cpsr_t low passes ARM words through unchanged
// o_half_offset marks a branch whose offset24 counts halfwords
`include "thumb_settings.svh"

module thumb_decompress_top
        import thumb_pkg::*;
(
        input  logic                    i_clk,
        input  logic                    i_rst,
        input  logic [`ARM_W-1:0]       i_instruction,
        input  logic                    i_instruction_valid,
        input  logic                    i_cpsr_t,
        output logic [`ARM_W-1:0]       o_instruction,
        output logic                    o_instruction_valid,
        output logic                    o_und,
        output logic                    o_half_offset
);

// Candidate words, all built from the same halfword
arm_word_u shift_arm;
arm_word_u addsub_arm;
arm_word_u imm8_arm;
arm_word_u lo_arm;
arm_word_u hi_arm;
arm_word_u bcond_arm;
arm_word_u buncond_arm;
arm_word_u bx_arm;
arm_word_u swi_arm;
logic      hi_und;

//////////////////////////////////////////////////
// Decoders and decode stage
//////////////////////////////////////////////////

thumb_dp_imm u_dp_imm (
        .i_thumb        (i_instruction[`THUMB_W-1:0]),
        .o_shift_arm    (shift_arm),
        .o_addsub_arm   (addsub_arm),
        .o_imm8_arm     (imm8_arm)
);

thumb_dp_alu u_dp_alu (
        .i_thumb        (i_instruction[`THUMB_W-1:0]),
        .o_lo_arm       (lo_arm),
        .o_hi_arm       (hi_arm),
        .o_hi_und       (hi_und)
);

thumb_branch_dec u_branch_dec (
        .i_thumb        (i_instruction[`THUMB_W-1:0]),
        .o_bcond_arm    (bcond_arm),
        .o_buncond_arm  (buncond_arm),
        .o_bx_arm       (bx_arm),
        .o_swi_arm      (swi_arm)
);

thumb_decode_stage u_decode_stage (
        .i_clk                  (i_clk),
        .i_rst                  (i_rst),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_cpsr_t               (i_cpsr_t),
        .i_shift_arm            (shift_arm),
        .i_addsub_arm           (addsub_arm),
        .i_imm8_arm             (imm8_arm),
        .i_lo_arm               (lo_arm),
        .i_hi_arm               (hi_arm),
        .i_bcond_arm            (bcond_arm),
        .i_buncond_arm          (buncond_arm),
        .i_bx_arm               (bx_arm),
        .i_swi_arm              (swi_arm),
        .i_hi_und               (hi_und),
        .o_instruction          (o_instruction),
        .o_instruction_valid    (o_instruction_valid),
        .o_und                  (o_und),
        .o_half_offset          (o_half_offset)
);

endmodule

/* test/tb_thumb_vectors.svh */
// Hand written vectors for the Thumb decompressor, one row per fetched word
// Columns are {input word, valid, T, expected ARM word, und, half, check word}
// Check word 0 leaves o_instruction unchecked, as for dropped formats
// Valid 0 rows check only o_instruction_valid
`ifndef TB_THUMB_VECTORS_SVH
`define TB_THUMB_VECTORS_SVH

localparam int NUM_VEC = 52;

logic [68:0] vec_table [NUM_VEC];       // 32 + 2 + 32 + 3 bits

task automatic fill_vector_table();
begin
        // ARM state, word passes untouched
        vec_table[0]  = {32'hE59F_1004, 2'b10, 32'hE59F_1004, 3'b001};
        vec_table[1]  = {32'h1234_5678, 2'b10, 32'h1234_5678, 3'b001};
        vec_table[2]  = {32'h0000_22A5, 2'b01, 32'h0000_0000, 3'b000};  // Strobe low

        //////////////////////////////////////////////////
        // Shift, add/sub low, 8-bit immediate
        //////////////////////////////////////////////////
        vec_table[3]  = {32'h0000_0151, 2'b11, 32'hE1B0_1282, 3'b001};  // LSL r1,r2,#5
        vec_table[4]  = {32'hFFFF_0FE3, 2'b11, 32'hE1B0_3FA4, 3'b001};  // LSR r3,r4,#31
        vec_table[5]  = {32'h0000_1078, 2'b11, 32'hE1B0_00C7, 3'b001};  // ASR r0,r7,#1
        vec_table[6]  = {32'h0000_18D1, 2'b11, 32'hE092_1003, 3'b001};  // ADD r1,r2,r3
        vec_table[7]  = {32'h0000_1FF5, 2'b11, 32'hE256_5007, 3'b001};  // SUB r5,r6,#7
        vec_table[8]  = {32'h0000_1C84, 2'b11, 32'hE290_4002, 3'b001};  // ADD r4,r0,#2
        vec_table[9]  = {32'h0000_1A53, 2'b11, 32'hE052_3001, 3'b001};  // SUB r3,r2,r1
        vec_table[10] = {32'h0000_22A5, 2'b11, 32'hE3B2_20A5, 3'b001};  // MOV r2,#0xA5
        vec_table[11] = {32'h0000_2FFF, 2'b11, 32'hE357_70FF, 3'b001};  // CMP r7,#0xFF
        vec_table[12] = {32'h0000_3301, 2'b11, 32'hE293_3001, 3'b001};  // ADD r3,#1
        vec_table[13] = {32'h0000_3880, 2'b11, 32'hE250_0080, 3'b001};  // SUB r0,#0x80

        // Low register ALU, all with Rd r1 and Rs r2
        vec_table[14] = {32'h0000_4011, 2'b11, 32'hE011_1002, 3'b001};  // AND
        vec_table[15] = {32'h0000_4051, 2'b11, 32'hE031_1002, 3'b001};  // EOR
        vec_table[16] = {32'h0000_4091, 2'b11, 32'hE1B1_1211, 3'b001};  // LSL by reg
        vec_table[17] = {32'h0000_40D1, 2'b11, 32'hE1B1_1231, 3'b001};  // LSR by reg
        vec_table[18] = {32'h0000_4111, 2'b11, 32'hE1B1_1251, 3'b001};  // ASR by reg
        vec_table[19] = {32'h0000_4151, 2'b11, 32'hE0B1_1002, 3'b001};  // ADC
        vec_table[20] = {32'h0000_4191, 2'b11, 32'hE0D1_1002, 3'b001};  // SBC
        vec_table[21] = {32'h0000_41D1, 2'b11, 32'hE1B1_1271, 3'b001};  // ROR by reg
        vec_table[22] = {32'h0000_4211, 2'b11, 32'hE111_1002, 3'b001};  // TST
        vec_table[23] = {32'h0000_4251, 2'b11, 32'hE272_1000, 3'b001};  // NEG as RSBS #0
        vec_table[24] = {32'h0000_4291, 2'b11, 32'hE151_1002, 3'b001};  // CMP
        vec_table[25] = {32'h0000_42D1, 2'b11, 32'hE171_1002, 3'b001};  // CMN
        vec_table[26] = {32'h0000_4311, 2'b11, 32'hE191_1002, 3'b001};  // ORR
        vec_table[27] = {32'h0000_4351, 2'b11, 32'hE011_0192, 3'b001};  // MULS r1,r2,r1
        vec_table[28] = {32'h0000_4391, 2'b11, 32'hE1D1_1002, 3'b001};  // BIC
        vec_table[29] = {32'h0000_43D1, 2'b11, 32'hE1F1_1002, 3'b001};  // MVN

        // High register
        vec_table[30] = {32'h0000_44E1, 2'b11, 32'hE089_900C, 3'b001};  // ADD r9,r12
        vec_table[31] = {32'h0000_4542, 2'b11, 32'hE152_2008, 3'b001};  // CMP r2,r8
        vec_table[32] = {32'h0000_469E, 2'b11, 32'hE1AE_E003, 3'b001};  // MOV lr,r3
        vec_table[33] = {32'h0000_4788, 2'b11, 32'h0000_0000, 3'b101};  // Op 3, bit 7 set

        //////////////////////////////////////////////////
        // Branches, BX, SWI
        //////////////////////////////////////////////////
        vec_table[34] = {32'h0000_4718, 2'b11, 32'hE12F_FF13, 3'b001};  // BX r3
        vec_table[35] = {32'hFFFF_4770, 2'b11, 32'hE12F_FF1E, 3'b001};  // BX lr
        vec_table[36] = {32'h0000_D004, 2'b11, 32'h0A00_0004, 3'b011};  // BEQ +4
        vec_table[37] = {32'h0000_D1FE, 2'b11, 32'h1AFF_FFFE, 3'b011};  // BNE -2
        vec_table[38] = {32'h0000_DC7F, 2'b11, 32'hCA00_007F, 3'b011};  // BGT max
        vec_table[39] = {32'h0000_DD80, 2'b11, 32'hDAFF_FF80, 3'b011};  // BLE min
        vec_table[40] = {32'h0000_DF42, 2'b11, 32'hEF00_0042, 3'b001};  // SWI over cond 1111
        vec_table[41] = {32'h0000_DFFF, 2'b11, 32'hEF00_00FF, 3'b001};
        vec_table[42] = {32'h0000_E123, 2'b11, 32'hEA00_0123, 3'b011};  // B +0x123
        vec_table[43] = {32'h0000_E7FE, 2'b11, 32'hEAFF_FFFE, 3'b011};  // B -2
        vec_table[44] = {32'h0000_E400, 2'b11, 32'hEAFF_FC00, 3'b011};  // B most negative

        // Dropped formats
        vec_table[45] = {32'h0000_6848, 2'b11, 32'h0000_0000, 3'b100};  // LDR r0,[r1,#4]
        vec_table[46] = {32'h0000_B510, 2'b11, 32'h0000_0000, 3'b100};  // PUSH {r4,lr}
        vec_table[47] = {32'h0000_4801, 2'b11, 32'h0000_0000, 3'b100};  // LDR r0,[pc,#4]
        vec_table[48] = {32'h0000_F000, 2'b11, 32'h0000_0000, 3'b100};  // BL prefix

        // Tail
        vec_table[49] = {32'h1234_5678, 2'b00, 32'h0000_0000, 3'b000};
        vec_table[50] = {32'hFFFF_DF01, 2'b10, 32'hFFFF_DF01, 3'b001};  // SWI look-alike, ARM
        vec_table[51] = {32'h0000_0000, 2'b11, 32'hE1B0_0000, 3'b001};  // LSL r0,r0,#0
end
endtask

`endif

/* test/tb_thumb_decompress.sv */
// Testbench for the Thumb decompressor, one row of the vector table per clock
// Rows are driven on the rising edge, results sampled on the falling edge
// First mismatch stops the run, a watchdog bounds the run time
`include "thumb_settings.svh"

module tb_thumb_decompress;

localparam int CLK_PERIOD = 10;

logic                   i_clk;
logic                   i_rst;
logic [`ARM_W-1:0]      i_instruction;
logic                   i_instruction_valid;
logic                   i_cpsr_t;
logic [`ARM_W-1:0]      o_instruction;
logic                   o_instruction_valid;
logic                   o_und;
logic                   o_half_offset;

`include "tb_thumb_vectors.svh"

thumb_decompress_top dut0 (
        .i_clk                  (i_clk),
        .i_rst                  (i_rst),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_cpsr_t               (i_cpsr_t),
        .o_instruction          (o_instruction),
        .o_instruction_valid    (o_instruction_valid),
        .o_und                  (o_und),
        .o_half_offset          (o_half_offset)
);

initial
        i_clk = 1'b0;

always #(CLK_PERIOD / 2) i_clk = ~i_clk;

//////////////////////////////////////////////////
// Helpers
//////////////////////////////////////////////////

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
begin
        if (actual !== expected)
        begin
                $display("[FAIL] time %0t %s actual 0x%0h expected 0x%0h",
                         $time, name, actual, expected);
                $display("TEST RESULT: FAIL");
                $fatal(1, "value mismatch on %s", name);
        end
end
endtask

// Input columns of one row onto the DUT
task automatic drive_row(input int idx);
        logic [`ARM_W-1:0]      in_word;
        logic                   in_valid;
        logic                   in_t;
begin
        in_word  = vec_table[idx][68:37];
        in_valid = vec_table[idx][36];
        in_t     = vec_table[idx][35];
        i_instruction       <= in_word;
        i_instruction_valid <= in_valid;
        i_cpsr_t            <= in_t;
end
endtask

// Expected columns of one row against the registered outputs
task automatic check_row(input int idx);
        logic [`ARM_W-1:0]      exp_word;
        logic                   exp_valid;
        logic                   exp_und;
        logic                   exp_half;
        logic                   chk_word;
begin
        exp_valid = vec_table[idx][36];
        exp_word  = vec_table[idx][34:3];
        exp_und   = vec_table[idx][2];
        exp_half  = vec_table[idx][1];
        chk_word  = vec_table[idx][0];
        check_value("o_instruction_valid", o_instruction_valid, exp_valid);
        if (exp_valid)                  // Other outputs are don't care otherwise
        begin
                check_value("o_und", o_und, exp_und);
                check_value("o_half_offset", o_half_offset, exp_half);
                if (chk_word)
                        check_value("o_instruction", o_instruction, exp_word);
        end
end
endtask

//////////////////////////////////////////////////
// Stimulus and checking
//////////////////////////////////////////////////

initial
begin
        i_rst               = 1'b1;
        i_instruction       = '0;
        i_instruction_valid = 1'b0;
        i_cpsr_t            = 1'b0;
        fill_vector_table();

        repeat (2) @(posedge i_clk);    // Two reset edges
        i_rst <= 1'b0;

        // Reset state
        @(negedge i_clk);
        check_value("o_instruction_valid", o_instruction_valid, 1'b0);
        check_value("o_und", o_und, 1'b0);
        check_value("o_half_offset", o_half_offset, 1'b0);
        check_value("o_instruction", o_instruction, 32'd0);

        // One cycle latency, so each falling edge shows the row before
        for (int idx = 0; idx < NUM_VEC; idx++)
        begin
                @(posedge i_clk);
                drive_row(idx);
                @(negedge i_clk);
                if (idx > 0)
                        check_row(idx - 1);
        end

        // Flush the last row with an idle cycle
        @(posedge i_clk);
        i_instruction_valid <= 1'b0;
        @(negedge i_clk);
        check_row(NUM_VEC - 1);

        $display("TEST RESULT: PASS");
        $finish;
end

// Watchdog, ten spare cycles over the table length
initial
begin
        #((NUM_VEC + 10) * CLK_PERIOD);
        $display("Watchdog expired: the test did not finish in time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog timeout");
end

endmodule

/* tb.f */
+incdir+rtl
+incdir+test
rtl/thumb_pkg.sv
rtl/thumb_dp_imm.sv
rtl/thumb_dp_alu.sv
rtl/thumb_branch_dec.sv
rtl/thumb_decode_stage.sv
rtl/thumb_decompress_top.sv
test/tb_thumb_decompress.sv
